// ==== src/trace_pkg.sv ====
// trace types shared by the ingress stage
// commit port, per-lane classification and E-Trace record layouts
package trace_pkg;

    // traced core data and address width
    localparam int XLEN        = 32;
    localparam int PRIV_LEN    = 2;
    localparam int CAUSE_LEN   = 5;
    // halfword count, largest value is 4
    localparam int IRETIRE_LEN = 3;
    localparam int ITYPE_LEN   = 3;

    // E-Trace instruction types used here
    typedef enum logic [ITYPE_LEN-1:0] {
        ITYPE_STD        = 3'd0,
        ITYPE_EXC        = 3'd1,
        ITYPE_INT        = 3'd2,
        ITYPE_ERET       = 3'd3,
        ITYPE_NT_BRANCH  = 3'd4,
        ITYPE_T_BRANCH   = 3'd5,
        ITYPE_UNINF_JUMP = 3'd6
    } itype_e;

    // class of the committed operation
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_JALR   = 2'd2,
        OP_ERET   = 2'd3
    } op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            compressed;
        op_e             op;
        // only meaningful for branches
        logic            taken;
    } commit_port_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        itype_e          itype;
        // halfwords, 1 or 2
        logic [1:0]      size;
    } lane_info_t;

    typedef struct packed {
        logic                   valid;
        logic [IRETIRE_LEN-1:0] iretire;
        logic                   ilastsize;
        itype_e                 itype;
        logic [CAUSE_LEN-1:0]   cause;
        logic [XLEN-1:0]        tval;
        logic [PRIV_LEN-1:0]    priv;
        logic [XLEN-1:0]        iaddr;
    } trace_rec_t;

endpackage

// ==== src/axil_pkg.sv ====
// AXI4-Lite channel bundles, response codes and register map
package axil_pkg;

    localparam int AXIL_AW = 4;
    localparam int AXIL_DW = 32;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // master to slave
    typedef struct packed {
        logic               awvalid;
        logic [AXIL_AW-1:0] awaddr;
        logic               wvalid;
        logic [AXIL_DW-1:0] wdata;
        logic               bready;
        logic               arvalid;
        logic [AXIL_AW-1:0] araddr;
        logic               rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        resp_e              bresp;
        logic               arready;
        logic               rvalid;
        logic [AXIL_DW-1:0] rdata;
        resp_e              rresp;
    } axil_rsp_t;

    // register offsets
    localparam logic [AXIL_AW-1:0] REG_CTRL      = 4'h0;
    localparam logic [AXIL_AW-1:0] REG_PRIV_MASK = 4'h4;
    localparam logic [AXIL_AW-1:0] REG_REC_CNT   = 4'h8;

endpackage

// ==== src/retire_classifier.sv ====
// retire classifier
// maps one commit port onto an E-Trace itype and a halfword size
module retire_classifier import trace_pkg::*; (
    input  commit_port_t port_i,
    output lane_info_t   lane_o
);

    itype_e itype;

    // operation class to itype
    always_comb begin
        case (port_i.op)
            OP_ALU: begin
                itype = ITYPE_STD;
            end
            OP_BRANCH: begin
                if (port_i.taken) begin
                    itype = ITYPE_T_BRANCH;
                end else begin
                    itype = ITYPE_NT_BRANCH;
                end
            end
            OP_JALR: begin
                itype = ITYPE_UNINF_JUMP;
            end
            OP_ERET: begin
                itype = ITYPE_ERET;
            end
            default: begin
                itype = ITYPE_STD;
            end
        endcase
    end

    always_comb begin
        lane_o.valid = port_i.valid;
        lane_o.pc    = port_i.pc;
        lane_o.itype = itype;
        // rvc instructions are one halfword
        if (port_i.compressed) begin
            lane_o.size = 2'd1;
        end else begin
            lane_o.size = 2'd2;
        end
    end

endmodule

// ==== src/retire_merger.sv ====
// retire merger
// filters by enable and privilege, injects traps, folds a std lane 0
// into lane 1, and registers both trace records
module retire_merger import trace_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  lane_info_t           lane0_i,
    input  lane_info_t           lane1_i,
    input  logic                 exc_valid_i,
    input  logic [CAUSE_LEN-1:0] exc_cause_i,
    input  logic [XLEN-1:0]      exc_tval_i,
    input  logic                 irq_valid_i,
    input  logic [CAUSE_LEN-1:0] irq_cause_i,
    input  logic [PRIV_LEN-1:0]  priv_i,
    input  logic                 trace_en_i,
    input  logic [3:0]           priv_mask_i,
    output trace_rec_t           rec0_o,
    output trace_rec_t           rec1_o,
    output logic [1:0]           emit_cnt_o
);

    trace_rec_t rec0_d;
    trace_rec_t rec1_d;
    logic       keep;
    logic       merge;

    // record for a lane that stands on its own
    function automatic trace_rec_t lane_rec(input lane_info_t lane,
                                            input logic [PRIV_LEN-1:0] priv);
        trace_rec_t rec;
        rec = '0;
        if (lane.valid) begin
            rec.valid     = 1'b1;
            rec.iretire   = IRETIRE_LEN'(lane.size);
            rec.ilastsize = (lane.size == 2'd2);
            rec.itype     = lane.itype;
            rec.priv      = priv;
            rec.iaddr     = lane.pc;
        end
        return rec;
    endfunction

    assign keep  = trace_en_i && priv_mask_i[priv_i];
    assign merge = lane0_i.valid && lane1_i.valid && (lane0_i.itype == ITYPE_STD);

    always_comb begin
        rec0_d = '0;
        rec1_d = '0;
        if (keep) begin
            if (exc_valid_i || irq_valid_i) begin
                // trap record sits on lane 0 only
                rec0_d.valid = 1'b1;
                rec0_d.iaddr = lane0_i.pc;
                rec0_d.priv  = priv_i;
                if (exc_valid_i) begin
                    rec0_d.itype = ITYPE_EXC;
                    rec0_d.cause = exc_cause_i;
                    rec0_d.tval  = exc_tval_i;
                end else begin
                    rec0_d.itype = ITYPE_INT;
                    rec0_d.cause = irq_cause_i;
                end
            end else if (merge) begin
                // std on lane 0 folds into the lane 1 record
                rec0_d.valid     = 1'b1;
                rec0_d.iretire   = IRETIRE_LEN'(lane0_i.size) + IRETIRE_LEN'(lane1_i.size);
                rec0_d.ilastsize = (lane1_i.size == 2'd2);
                rec0_d.itype     = lane1_i.itype;
                rec0_d.priv      = priv_i;
                rec0_d.iaddr     = lane0_i.pc;
            end else begin
                rec0_d = lane_rec(lane0_i, priv_i);
                rec1_d = lane_rec(lane1_i, priv_i);
            end
        end
    end

    // one cycle latency, outputs hold for a single cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec0_o     <= '0;
            rec1_o     <= '0;
            emit_cnt_o <= 2'd0;
        end else begin
            rec0_o     <= rec0_d;
            rec1_o     <= rec1_d;
            emit_cnt_o <= 2'(rec0_d.valid) + 2'(rec1_d.valid);
        end
    end

endmodule

// ==== src/trace_csr.sv ====
// trace control registers on an AXI4-Lite slave
// enable, privilege mask and a count of emitted records
module trace_csr import axil_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  axil_req_t  axil_req_i,
    output axil_rsp_t  axil_rsp_o,
    input  logic [1:0] emit_cnt_i,
    output logic       trace_en_o,
    output logic [3:0] priv_mask_o
);

    typedef enum logic {
        IDLE,
        RESP
    } state_e;

    state_e             wr_state;
    state_e             rd_state;
    logic               wr_fire;
    logic               rd_fire;
    logic               cnt_clr;
    resp_e              bresp_q;
    resp_e              rresp_q;
    logic [AXIL_DW-1:0] rdata_q;
    logic [AXIL_DW-1:0] rd_mux;
    logic [CNT_W-1:0]   rec_cnt;
    logic               en_q;
    logic [3:0]         mask_q;

    function automatic logic is_mapped(input logic [AXIL_AW-1:0] addr);
        return (addr == REG_CTRL) || (addr == REG_PRIV_MASK) || (addr == REG_REC_CNT);
    endfunction

    // address and data must both be present before accepting a write
    assign wr_fire = (wr_state == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_fire = (rd_state == IDLE) && axil_req_i.arvalid;
    assign cnt_clr = wr_fire && (axil_req_i.awaddr == REG_CTRL) && axil_req_i.wdata[1];

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bvalid  = (wr_state == RESP);
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = rd_fire;
        axil_rsp_o.rvalid  = (rd_state == RESP);
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

    // write channel
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_state <= IDLE;
            bresp_q  <= RESP_OKAY;
            en_q     <= 1'b0;
            mask_q   <= 4'hF;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (wr_fire) begin
                        wr_state <= RESP;
                        bresp_q  <= is_mapped(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
                        if (axil_req_i.awaddr == REG_CTRL) begin
                            en_q <= axil_req_i.wdata[0];
                        end
                        if (axil_req_i.awaddr == REG_PRIV_MASK) begin
                            mask_q <= axil_req_i.wdata[3:0];
                        end
                    end
                end
                RESP: begin
                    if (axil_req_i.bready) begin
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    // wraps on overflow
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec_cnt <= '0;
        end else if (cnt_clr) begin
            rec_cnt <= '0;
        end else begin
            rec_cnt <= rec_cnt + CNT_W'(emit_cnt_i);
        end
    end

    always_comb begin
        case (axil_req_i.araddr)
            REG_CTRL:      rd_mux = AXIL_DW'(en_q);
            REG_PRIV_MASK: rd_mux = AXIL_DW'(mask_q);
            REG_REC_CNT:   rd_mux = AXIL_DW'(rec_cnt);
            default:       rd_mux = '0;
        endcase
    end

    // read channel
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_state <= IDLE;
            rresp_q  <= RESP_OKAY;
            rdata_q  <= '0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (rd_fire) begin
                        rd_state <= RESP;
                        rdata_q  <= rd_mux;
                        rresp_q  <= is_mapped(axil_req_i.araddr) ? RESP_OKAY : RESP_SLVERR;
                    end
                end
                RESP: begin
                    if (axil_req_i.rready) begin
                        rd_state <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    assign trace_en_o  = en_q;
    assign priv_mask_o = mask_q;

endmodule

// ==== src/trace_ingress_top.sv ====
// trace ingress top
// two commit classifiers feeding the merger, with a register block on AXI4-Lite
module trace_ingress_top import trace_pkg::*, axil_pkg::*; #(
    parameter int CNT_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  commit_port_t         commit0_i,
    input  commit_port_t         commit1_i,
    input  logic                 exc_valid_i,
    input  logic [CAUSE_LEN-1:0] exc_cause_i,
    input  logic [XLEN-1:0]      exc_tval_i,
    input  logic                 irq_valid_i,
    input  logic [CAUSE_LEN-1:0] irq_cause_i,
    input  logic [PRIV_LEN-1:0]  priv_i,
    input  axil_req_t            axil_req_i,
    output trace_rec_t           rec0_o,
    output trace_rec_t           rec1_o,
    output axil_rsp_t            axil_rsp_o
);

    lane_info_t lane0;
    lane_info_t lane1;
    logic       trace_en;
    logic [3:0] priv_mask;
    logic [1:0] emit_cnt;

    retire_classifier u_cls0 (
        .port_i (commit0_i),
        .lane_o (lane0)
    );

    retire_classifier u_cls1 (
        .port_i (commit1_i),
        .lane_o (lane1)
    );

    retire_merger u_merger (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lane0_i     (lane0),
        .lane1_i     (lane1),
        .exc_valid_i (exc_valid_i),
        .exc_cause_i (exc_cause_i),
        .exc_tval_i  (exc_tval_i),
        .irq_valid_i (irq_valid_i),
        .irq_cause_i (irq_cause_i),
        .priv_i      (priv_i),
        .trace_en_i  (trace_en),
        .priv_mask_i (priv_mask),
        .rec0_o      (rec0_o),
        .rec1_o      (rec1_o),
        .emit_cnt_o  (emit_cnt)
    );

    trace_csr #(
        .CNT_W (CNT_W)
    ) u_csr (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .emit_cnt_i  (emit_cnt),
        .trace_en_o  (trace_en),
        .priv_mask_o (priv_mask)
    );

endmodule

// ==== test/clk_gen.sv ====
// testbench clock source
// free-running clock, starts low
module clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== test/tb_trace_ingress.sv ====
// testbench for the trace ingress stage
// random commits checked against a reference model, registers over AXI4-Lite
module tb_trace_ingress import trace_pkg::*, axil_pkg::*; ();

    localparam int AXI_TIMEOUT = 20;

    logic                 clk;
    logic                 rst_n_i;
    commit_port_t         commit0;
    commit_port_t         commit1;
    logic                 exc_valid;
    logic [CAUSE_LEN-1:0] exc_cause;
    logic [XLEN-1:0]      exc_tval;
    logic                 irq_valid;
    logic [CAUSE_LEN-1:0] irq_cause;
    logic [PRIV_LEN-1:0]  priv;
    axil_req_t            axil_req;
    axil_rsp_t            axil_rsp;
    trace_rec_t           rec0;
    trace_rec_t           rec1;

    // reference model state
    trace_rec_t           exp0;
    trace_rec_t           exp1;
    logic                 model_en;
    logic [3:0]           model_mask;
    logic [31:0]          model_cnt;

    clk_gen #(
        .PERIOD (8)
    ) u_clk (
        .clk (clk)
    );

    trace_ingress_top #(
        .CNT_W (32)
    ) UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .commit0_i   (commit0),
        .commit1_i   (commit1),
        .exc_valid_i (exc_valid),
        .exc_cause_i (exc_cause),
        .exc_tval_i  (exc_tval),
        .irq_valid_i (irq_valid),
        .irq_cause_i (irq_cause),
        .priv_i      (priv),
        .axil_req_i  (axil_req),
        .rec0_o      (rec0),
        .rec1_o      (rec1),
        .axil_rsp_o  (axil_rsp)
    );

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_on_stall(input string what);
        $display("timeout at time %0t: no %s from the DUT", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "bus handshake timed out");
    endtask

    task automatic compare_record(input string lane, input trace_rec_t act,
                                  input trace_rec_t exp);
        compare_value({lane, ".valid"}, 32'(act.valid), 32'(exp.valid));
        compare_value({lane, ".iretire"}, 32'(act.iretire), 32'(exp.iretire));
        compare_value({lane, ".ilastsize"}, 32'(act.ilastsize), 32'(exp.ilastsize));
        compare_value({lane, ".itype"}, 32'(act.itype), 32'(exp.itype));
        compare_value({lane, ".cause"}, 32'(act.cause), 32'(exp.cause));
        compare_value({lane, ".tval"}, act.tval, exp.tval);
        compare_value({lane, ".priv"}, 32'(act.priv), 32'(exp.priv));
        compare_value({lane, ".iaddr"}, act.iaddr, exp.iaddr);
    endtask

    function automatic itype_e expected_itype(input commit_port_t c);
        case (c.op)
            OP_BRANCH: return c.taken ? ITYPE_T_BRANCH : ITYPE_NT_BRANCH;
            OP_JALR:   return ITYPE_UNINF_JUMP;
            OP_ERET:   return ITYPE_ERET;
            default:   return ITYPE_STD;
        endcase
    endfunction

    // rvc counts one halfword and everything else two
    function automatic logic [IRETIRE_LEN-1:0] halfwords(input commit_port_t c);
        return c.compressed ? 3'd1 : 3'd2;
    endfunction

    function automatic trace_rec_t single_record(input commit_port_t c);
        trace_rec_t r;
        r = '0;
        if (c.valid) begin
            r.valid     = 1'b1;
            r.iretire   = halfwords(c);
            r.ilastsize = (halfwords(c) == 3'd2);
            r.itype     = expected_itype(c);
            r.priv      = priv;
            r.iaddr     = c.pc;
        end
        return r;
    endfunction

    // expected records for the inputs currently driven
    task automatic predict_records();
        trace_rec_t r0;
        trace_rec_t r1;
        r0 = '0;
        r1 = '0;
        if (model_en && model_mask[priv]) begin
            if (exc_valid || irq_valid) begin
                // exception wins over interrupt
                r0.valid = 1'b1;
                r0.iaddr = commit0.pc;
                r0.priv  = priv;
                r0.itype = exc_valid ? ITYPE_EXC : ITYPE_INT;
                r0.cause = exc_valid ? exc_cause : irq_cause;
                r0.tval  = exc_valid ? exc_tval : '0;
            end else if (commit0.valid && commit1.valid &&
                         expected_itype(commit0) == ITYPE_STD) begin
                r0.valid     = 1'b1;
                r0.iretire   = halfwords(commit0) + halfwords(commit1);
                r0.ilastsize = (halfwords(commit1) == 3'd2);
                r0.itype     = expected_itype(commit1);
                r0.priv      = priv;
                r0.iaddr     = commit0.pc;
            end else begin
                r0 = single_record(commit0);
                r1 = single_record(commit1);
            end
        end
        exp0      = r0;
        exp1      = r1;
        model_cnt = model_cnt + 32'(r0.valid) + 32'(r1.valid);
    endtask

    function automatic commit_port_t random_port();
        commit_port_t p;
        p.valid      = ($urandom % 4) != 0;
        p.pc         = $urandom & 32'hFFFF_FFFE;
        p.compressed = ($urandom % 2) == 1;
        p.op         = op_e'(2'($urandom % 4));
        p.taken      = ($urandom % 2) == 1;
        return p;
    endfunction

    task automatic randomize_inputs(input logic with_traps);
        commit0   = random_port();
        commit1   = random_port();
        priv      = PRIV_LEN'($urandom % 4);
        exc_valid = with_traps && (($urandom % 5) == 0);
        exc_cause = CAUSE_LEN'($urandom);
        exc_tval  = $urandom;
        irq_valid = with_traps && (($urandom % 4) == 0);
        irq_cause = CAUSE_LEN'($urandom);
    endtask

    task automatic drive_idle();
        commit0   = '0;
        commit1   = '0;
        exc_valid = 1'b0;
        exc_cause = '0;
        exc_tval  = '0;
        irq_valid = 1'b0;
        irq_cause = '0;
        priv      = '0;
    endtask

    // one clock and a compare of both record outputs
    task automatic step_and_check();
        @(posedge clk);
        #1;
        compare_record("rec0", rec0, exp0);
        compare_record("rec1", rec1, exp1);
    endtask

    task automatic run_random(input int cycles, input logic with_traps);
        for (int i = 0; i < cycles; i++) begin
            randomize_inputs(with_traps);
            predict_records();
            step_and_check();
        end
        // let the counter take the last emit count
        drive_idle();
        predict_records();
        step_and_check();
        step_and_check();
    endtask

    task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.bready  = 1'b1;
        #1;
        waited = 0;
        while (!axil_rsp.awready || !axil_rsp.wready) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (waited > AXI_TIMEOUT) begin
                abort_on_stall("write address and data ready");
            end
        end
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        waited = 0;
        while (!axil_rsp.bvalid) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (waited > AXI_TIMEOUT) begin
                abort_on_stall("write response");
            end
        end
        resp = axil_rsp.bresp;
        @(posedge clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [AXIL_AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        #1;
        waited = 0;
        while (!axil_rsp.arready) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (waited > AXI_TIMEOUT) begin
                abort_on_stall("read address ready");
            end
        end
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b0;
        waited = 0;
        while (!axil_rsp.rvalid) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (waited > AXI_TIMEOUT) begin
                abort_on_stall("read data");
            end
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic [1:0]  resp;
        logic [3:0]  new_mask;
        void'($urandom(32'ha169));
        rst_n_i    = 1'b0;
        axil_req   = '0;
        model_en   = 1'b0;
        model_mask = 4'hF;
        model_cnt  = '0;
        exp0       = '0;
        exp1       = '0;
        drive_idle();
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // records and bus handshakes come out of reset idle
        compare_record("rec0 after reset", rec0, '0);
        compare_record("rec1 after reset", rec1, '0);
        compare_value("axi ready and valid after reset",
                      32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                           axil_rsp.arready, axil_rsp.rvalid}), 32'h0);

        // tracing still disabled
        run_random(100, 1'b1);
        read_reg(REG_PRIV_MASK, rdata, resp);
        compare_value("priv mask after reset", rdata, 32'hF);
        compare_value("priv mask rresp", 32'(resp), 32'(RESP_OKAY));

        write_reg(REG_CTRL, 32'h1, resp);
        compare_value("ctrl bresp", 32'(resp), 32'(RESP_OKAY));
        model_en = 1'b1;
        run_random(500, 1'b0);

        // traps mixed in
        run_random(300, 1'b1);

        // partial privilege mask
        new_mask = 4'($urandom_range(1, 14));
        write_reg(REG_PRIV_MASK, 32'(new_mask), resp);
        compare_value("mask bresp", 32'(resp), 32'(RESP_OKAY));
        model_mask = new_mask;
        read_reg(REG_PRIV_MASK, rdata, resp);
        compare_value("priv mask readback", rdata, 32'(new_mask));
        run_random(300, 1'b1);

        read_reg(REG_REC_CNT, rdata, resp);
        compare_value("record count", rdata, model_cnt);
        compare_value("record count rresp", 32'(resp), 32'(RESP_OKAY));

        // clear the counter with tracing left on
        write_reg(REG_CTRL, 32'h3, resp);
        model_cnt = '0;
        read_reg(REG_REC_CNT, rdata, resp);
        compare_value("record count after clear", rdata, 32'h0);
        run_random(50, 1'b0);
        read_reg(REG_REC_CNT, rdata, resp);
        compare_value("record count after restart", rdata, model_cnt);

        read_reg(4'hC, rdata, resp);
        compare_value("unmapped read data", rdata, 32'h0);
        compare_value("unmapped rresp", 32'(resp), 32'(RESP_SLVERR));
        write_reg(4'hC, 32'hFFFF_FFFF, resp);
        compare_value("unmapped bresp", 32'(resp), 32'(RESP_SLVERR));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
src/trace_pkg.sv
src/axil_pkg.sv
src/retire_classifier.sv
src/retire_merger.sv
src/trace_csr.sv
src/trace_ingress_top.sv
test/clk_gen.sv
test/tb_trace_ingress.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_trace_ingress
RTL_TOP    = trace_ingress_top
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = CHECKS FAILED
PASS_MSG   = ALL CHECKS PASSED

SOURCES    = $(shell cat $(FILELIST))
RTL_SRCS   = $(filter src/%,$(SOURCES))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
